// File: src/copper_isa_pkg.sv
/*
 * Copper instruction set encodings and FSM states.
 * The opcode sits in bits 15..14 of every instruction word.
 */
package copper_isa_pkg;

    // opcode, instruction bits 15..14
    typedef enum logic [1:0] {
        op_set_target       = 2'd0,
        op_write_compressed = 2'd1,
        op_write_reg        = 2'd2,
        op_jump             = 2'd3
    } copper_op_t;

    // register write batch size, instruction bits 13..12
    typedef enum logic [1:0] {
        inc_batch_1   = 2'd0,
        inc_batch_2   = 2'd1,
        inc_batch_4   = 2'd2,
        inc_reserved  = 2'd3
    } write_inc_mode_t;

    // copper sequencer states
    typedef enum logic [1:0] {
        op_fetch    = 2'd0,
        data_fetch  = 2'd1,
        raster_wait = 2'd2
    } copper_state_t;

endpackage

// File: src/copper_ram.sv
`timescale 1ns/1ps

/*
 * Copper program memory. The host loads words through the write port;
 * the copper reads combinationally so an instruction is visible in the
 * same cycle its address is presented.
 */
module copper_ram #(
    parameter int COPPER_DEPTH = 2048
) (
    input  logic                        clk,
    input  logic                        prog_we,
    input  vdp_types_pkg::copper_addr_t prog_addr,
    input  vdp_types_pkg::copper_word_t prog_data,
    input  vdp_types_pkg::copper_addr_t read_addr,
    output vdp_types_pkg::copper_word_t read_data
);

    vdp_types_pkg::copper_word_t mem [COPPER_DEPTH];

    // host load
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // instruction fetch path
    assign read_data = mem[read_addr];

endmodule

// File: src/raster_timer.sv
`timescale 1ns/1ps

/*
 * Beam position generator: column counts every cycle, line advances
 * when the column wraps. Frame size comes from H_TOTAL and V_TOTAL.
 */
module raster_timer #(
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic                     clk,
    input  logic                     rst_n,
    output vdp_types_pkg::raster_x_t raster_x,
    output vdp_types_pkg::raster_y_t raster_y
);

    localparam vdp_types_pkg::raster_x_t X_LAST = vdp_types_pkg::raster_x_t'(H_TOTAL - 1);
    localparam vdp_types_pkg::raster_y_t Y_LAST = vdp_types_pkg::raster_y_t'(V_TOTAL - 1);

    logic line_end;

    assign line_end = (raster_x == X_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raster_x <= '0;
            raster_y <= '0;
        end else begin
            if (line_end) begin
                raster_x <= '0;
                // next line, wrapping at the frame end
                if (raster_y == Y_LAST) begin
                    raster_y <= '0;
                end else begin
                    raster_y <= raster_y + 10'd1;
                end
            end else begin
                raster_x <= raster_x + 11'd1;
            end
        end
    end

endmodule

// File: src/vdp_copper.sv
`timescale 1ns/1ps

/*
 * Copper coprocessor. Fetches instructions from copper RAM at pc and
 * writes VDP registers, optionally waiting for a beam position first.
 * Held at pc 0 with no writes while enable is low.
 */
module vdp_copper (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         enable,
    input  vdp_types_pkg::raster_x_t     raster_x,
    input  vdp_types_pkg::raster_y_t     raster_y,
    output vdp_types_pkg::copper_addr_t  ram_read_address,
    input  vdp_types_pkg::copper_word_t  ram_read_data,
    output vdp_types_pkg::vdp_reg_addr_t reg_write_address,
    output vdp_types_pkg::vdp_reg_data_t reg_write_data,
    output logic                         reg_write_en
);

    // sequencer state
    vdp_types_pkg::copper_addr_t   pc;
    copper_isa_pkg::copper_state_t state;
    logic                          write_pulse;
    logic                          resume_data;

    // raster target
    vdp_types_pkg::raster_x_t target_x;
    vdp_types_pkg::raster_y_t target_y;
    logic                     target_hit;

    // decoded fields of the word at pc
    copper_isa_pkg::copper_op_t      op;
    logic                            tgt_wait;
    logic                            tgt_select;
    logic [10:0]                     tgt_value;
    copper_isa_pkg::write_inc_mode_t wr_inc_mode;
    logic                            wr_auto_wait;
    logic [4:0]                      wr_batch_count;
    vdp_types_pkg::vdp_reg_addr_t    wr_base_reg;
    logic                            cmp_next_line;
    logic [4:0]                      cmp_data;
    vdp_types_pkg::vdp_reg_addr_t    cmp_reg;
    vdp_types_pkg::copper_addr_t     jump_target;

    // register write fields latched from the header
    vdp_types_pkg::vdp_reg_addr_t    base_reg_q;
    logic [4:0]                      batch_count_q;
    logic                            auto_wait_q;
    copper_isa_pkg::write_inc_mode_t inc_mode_q;
    logic [1:0]                      word_count_q;

    logic [1:0] reg_offset;
    logic       batch_done;

    assign ram_read_address = pc;
    assign target_hit = (raster_x == target_x) && (raster_y == target_y);

    // field layout
    //   set target  oo-w svvv vvvv vvvv
    //   write reg   ooii ynnn nnrr rrrr
    //   compressed  oo-- yddd ddrr rrrr
    //   jump        oo-- -aaa aaaa aaaa
    assign op             = copper_isa_pkg::copper_op_t'(ram_read_data[15:14]);
    assign tgt_wait       = ram_read_data[12];
    assign tgt_select     = ram_read_data[11];
    assign tgt_value      = ram_read_data[10:0];
    assign wr_inc_mode    = copper_isa_pkg::write_inc_mode_t'(ram_read_data[13:12]);
    assign wr_auto_wait   = ram_read_data[11];
    assign wr_batch_count = ram_read_data[10:6];
    assign wr_base_reg    = ram_read_data[5:0];
    assign cmp_next_line  = ram_read_data[11];
    assign cmp_data       = ram_read_data[10:6];
    assign cmp_reg        = ram_read_data[5:0];
    assign jump_target    = ram_read_data[10:0];

    // register offset within the batch and end of batch
    always_comb begin
        case (inc_mode_q)
            copper_isa_pkg::inc_batch_2: begin
                reg_offset = word_count_q & 2'b01;
                batch_done = word_count_q[0];
            end
            copper_isa_pkg::inc_batch_4: begin
                reg_offset = word_count_q;
                batch_done = (word_count_q == 2'b11);
            end
            // reserved mode runs as single-register batches
            default: begin
                reg_offset = 2'b00;
                batch_done = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc            <= '0;
            state         <= copper_isa_pkg::op_fetch;
            write_pulse   <= 1'b0;
            resume_data   <= 1'b0;
            target_x      <= '0;
            target_y      <= '0;
            base_reg_q    <= '0;
            batch_count_q <= '0;
            auto_wait_q   <= 1'b0;
            inc_mode_q    <= copper_isa_pkg::inc_batch_1;
            word_count_q  <= '0;
        end else if (!enable) begin
            // disabled copper sits at the program start
            pc          <= '0;
            state       <= copper_isa_pkg::op_fetch;
            write_pulse <= 1'b0;
        end else begin
            write_pulse <= 1'b0;

            case (state)
                copper_isa_pkg::op_fetch: begin
                    case (op)
                        copper_isa_pkg::op_set_target: begin
                            if (tgt_select) begin
                                target_y <= tgt_value[9:0];
                            end else begin
                                target_x <= tgt_value;
                            end
                            // pc stays put while waiting, advances on the hit
                            if (tgt_wait) begin
                                resume_data <= 1'b0;
                                state       <= copper_isa_pkg::raster_wait;
                            end else begin
                                pc <= pc + 11'd1;
                            end
                        end
                        copper_isa_pkg::op_write_compressed: begin
                            write_pulse <= 1'b1;
                            if (cmp_next_line) begin
                                target_y <= raster_y + 10'd1;
                            end
                            pc <= pc + 11'd1;
                        end
                        copper_isa_pkg::op_write_reg: begin
                            base_reg_q    <= wr_base_reg;
                            batch_count_q <= wr_batch_count;
                            auto_wait_q   <= wr_auto_wait;
                            inc_mode_q    <= wr_inc_mode;
                            word_count_q  <= '0;
                            state         <= copper_isa_pkg::data_fetch;
                            pc            <= pc + 11'd1;
                        end
                        default: begin
                            pc <= jump_target;
                        end
                    endcase
                end

                copper_isa_pkg::data_fetch: begin
                    write_pulse  <= 1'b1;
                    word_count_q <= word_count_q + 2'd1;

                    if (!batch_done) begin
                        pc <= pc + 11'd1;
                    end else if (batch_count_q == 5'd0) begin
                        // last batch written
                        state <= copper_isa_pkg::op_fetch;
                        pc    <= pc + 11'd1;
                    end else begin
                        batch_count_q <= batch_count_q - 5'd1;
                        if (auto_wait_q) begin
                            target_y    <= raster_y + 10'd1;
                            resume_data <= 1'b1;
                            state       <= copper_isa_pkg::raster_wait;
                        end else begin
                            pc <= pc + 11'd1;
                        end
                    end
                end

                default: begin
                    if (target_hit) begin
                        if (resume_data) begin
                            state <= copper_isa_pkg::data_fetch;
                        end else begin
                            state <= copper_isa_pkg::op_fetch;
                        end
                        pc <= pc + 11'd1;
                    end
                end
            endcase
        end
    end

    // write address and data, qualified by write_pulse
    always_ff @(posedge clk) begin
        if (state == copper_isa_pkg::op_fetch && op == copper_isa_pkg::op_write_compressed) begin
            reg_write_address <= cmp_reg;
            reg_write_data    <= vdp_types_pkg::vdp_reg_data_t'(cmp_data);
        end else if (state == copper_isa_pkg::data_fetch) begin
            reg_write_address <= base_reg_q + vdp_types_pkg::vdp_reg_addr_t'(reg_offset);
            reg_write_data    <= ram_read_data;
        end
    end

    // a pending pulse is dropped as soon as enable falls
    assign reg_write_en = write_pulse && enable;

endmodule

// File: src/vdp_copper_top.sv
`timescale 1ns/1ps

/*
 * Copper subsystem top level: raster timer, copper RAM, copper and
 * register file. The host loads the program with prog_we while enable
 * is low, then raises enable and watches or reads back the registers.
 */
module vdp_copper_top #(
    parameter int H_TOTAL      = 800,
    parameter int V_TOTAL      = 525,
    parameter int COPPER_DEPTH = 2048
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         enable,
    input  logic                         prog_we,
    input  vdp_types_pkg::copper_addr_t  prog_addr,
    input  vdp_types_pkg::copper_word_t  prog_data,
    input  vdp_types_pkg::vdp_reg_addr_t reg_read_address,
    output vdp_types_pkg::raster_x_t     raster_x,
    output vdp_types_pkg::raster_y_t     raster_y,
    output logic                         reg_write_en,
    output vdp_types_pkg::vdp_reg_addr_t reg_write_address,
    output vdp_types_pkg::vdp_reg_data_t reg_write_data,
    output vdp_types_pkg::vdp_reg_data_t reg_read_data
);

    vdp_types_pkg::copper_addr_t ram_read_address;
    vdp_types_pkg::copper_word_t ram_read_data;

    raster_timer #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) u_raster_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .raster_x (raster_x),
        .raster_y (raster_y)
    );

    copper_ram #(
        .COPPER_DEPTH (COPPER_DEPTH)
    ) u_copper_ram (
        .clk       (clk),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .read_addr (ram_read_address),
        .read_data (ram_read_data)
    );

    vdp_copper u_vdp_copper (
        .clk               (clk),
        .rst_n             (rst_n),
        .enable            (enable),
        .raster_x          (raster_x),
        .raster_y          (raster_y),
        .ram_read_address  (ram_read_address),
        .ram_read_data     (ram_read_data),
        .reg_write_address (reg_write_address),
        .reg_write_data    (reg_write_data),
        .reg_write_en      (reg_write_en)
    );

    vdp_reg_file u_vdp_reg_file (
        .clk               (clk),
        .rst_n             (rst_n),
        .reg_write_address (reg_write_address),
        .reg_write_data    (reg_write_data),
        .reg_write_en      (reg_write_en),
        .reg_read_address  (reg_read_address),
        .reg_read_data     (reg_read_data)
    );

endmodule

// File: src/vdp_reg_file.sv
`timescale 1ns/1ps

/*
 * VDP control register storage, 64 x 16 bits.
 * Written by the copper, read back by the host without latency.
 */
module vdp_reg_file (
    input  logic                         clk,
    input  logic                         rst_n,
    input  vdp_types_pkg::vdp_reg_addr_t reg_write_address,
    input  vdp_types_pkg::vdp_reg_data_t reg_write_data,
    input  logic                         reg_write_en,
    input  vdp_types_pkg::vdp_reg_addr_t reg_read_address,
    output vdp_types_pkg::vdp_reg_data_t reg_read_data
);

    localparam int REG_COUNT = 64;

    vdp_types_pkg::vdp_reg_data_t regs [REG_COUNT];

    // registers come up cleared
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (reg_write_en) begin
            regs[reg_write_address] <= reg_write_data;
        end
    end

    // host read back
    assign reg_read_data = regs[reg_read_address];

endmodule

// File: src/vdp_types_pkg.sv
/*
 * Width types shared by the VDP blocks.
 * Covers beam position, copper program words and register file fields.
 */
package vdp_types_pkg;

    // beam position
    typedef logic [10:0] raster_x_t;
    typedef logic [9:0]  raster_y_t;

    // copper program memory
    typedef logic [10:0] copper_addr_t;
    typedef logic [15:0] copper_word_t;

    // VDP register file
    typedef logic [5:0]  vdp_reg_addr_t;
    typedef logic [15:0] vdp_reg_data_t;

endpackage

// File: verification/vdp_copper_assertions.sv
`timescale 1ns/1ps

/*
 * Concurrent checks on the copper, bound into every vdp_copper instance.
 * Covers enable gating, the reserved increment mode and write pulse sources.
 */
module vdp_copper_assertions (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            enable,
    input logic                            reg_write_en,
    input copper_isa_pkg::copper_state_t   state,
    input copper_isa_pkg::copper_op_t      op,
    input copper_isa_pkg::write_inc_mode_t inc_mode_q
);

    // a disabled copper leaves no pulse pending for the next cycle
    no_write_when_disabled: assert property (@(posedge clk) disable iff (!rst_n)
        !enable |=> !reg_write_en)
        else $error("reg_write_en high in the cycle after enable was low");

    // mode 3 runs as mode 0 but should never appear in a program
    no_reserved_mode: assert property (@(posedge clk) disable iff (!rst_n)
        state == copper_isa_pkg::data_fetch |-> inc_mode_q != copper_isa_pkg::inc_reserved)
        else $error("register write uses the reserved increment mode");

    // one pulse per compressed fetch, in the next cycle
    compressed_gives_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        enable && state == copper_isa_pkg::op_fetch
            && op == copper_isa_pkg::op_write_compressed
        |=> reg_write_en || !enable)
        else $error("compressed write fetched without a write pulse");

    // pulses only follow a compressed fetch or a data word
    pulse_has_source: assert property (@(posedge clk) disable iff (!rst_n)
        reg_write_en |-> $past((state == copper_isa_pkg::op_fetch
            && op == copper_isa_pkg::op_write_compressed)
            || state == copper_isa_pkg::data_fetch))
        else $error("write pulse without a compressed fetch or data word");

endmodule

bind vdp_copper vdp_copper_assertions u_copper_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable       (enable),
    .reg_write_en (reg_write_en),
    .state        (state),
    .op           (op),
    .inc_mode_q   (inc_mode_q)
);

// File: verification/vdp_copper_tb.sv
`timescale 1ns/1ps

/*
 * Testbench for the copper subsystem. Builds random copper programs, runs
 * them on a small frame and checks every register write and the host read
 * back against a model of the instruction set.
 */
module vdp_copper_tb;

    localparam int H_TOTAL = 24;
    localparam int V_TOTAL = 12;
    localparam int TEST_LIMIT = 2 * H_TOTAL * V_TOTAL;
    // program runs over all tests, each with load, settle and read back
    localparam int NUM_RUNS = 9;
    localparam int RUN_LIMIT = NUM_RUNS * (TEST_LIMIT + 100) + 500;
    // hit cycle, fetch cycle, then the write pulse
    localparam int HIT_TO_WRITE = 2;

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic                         enable;
    logic                         prog_we;
    vdp_types_pkg::copper_addr_t  prog_addr;
    vdp_types_pkg::copper_word_t  prog_data;
    vdp_types_pkg::vdp_reg_addr_t reg_read_address;
    vdp_types_pkg::raster_x_t     raster_x;
    vdp_types_pkg::raster_y_t     raster_y;
    logic                         reg_write_en;
    vdp_types_pkg::vdp_reg_addr_t reg_write_address;
    vdp_types_pkg::vdp_reg_data_t reg_write_data;
    vdp_types_pkg::vdp_reg_data_t reg_read_data;

    integer seed = 32'h7e78;
    int     errors = 0;
    int     errors_before = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     cycles = 0;

    vdp_types_pkg::copper_word_t prog [$];
    int exp_addr [$];
    int exp_data [$];
    int exp_batch [$];
    int got_addr [$];
    int got_data [$];
    int got_x [$];
    int got_y [$];

    vdp_copper_top #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) u_vdp_copper_top (
        .clk               (clk),
        .rst_n             (rst_n),
        .enable            (enable),
        .prog_we           (prog_we),
        .prog_addr         (prog_addr),
        .prog_data         (prog_data),
        .reg_read_address  (reg_read_address),
        .raster_x          (raster_x),
        .raster_y          (raster_y),
        .reg_write_en      (reg_write_en),
        .reg_write_address (reg_write_address),
        .reg_write_data    (reg_write_data),
        .reg_read_data     (reg_read_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= RUN_LIMIT) begin
            $display("run stopped at cycle limit %0d before all tests finished", RUN_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // write monitor, sampled mid cycle where everything is stable
    always @(negedge clk) begin
        if (reg_write_en === 1'b1) begin
            got_addr.push_back(reg_write_address);
            got_data.push_back(reg_write_data);
            got_x.push_back(raster_x);
            got_y.push_back(raster_y);
        end
    end

    function automatic int pick(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // instruction encoders
    function automatic vdp_types_pkg::copper_word_t target_word(logic hold, logic is_y, int v);
        return {copper_isa_pkg::op_set_target, 1'b0, hold, is_y, 11'(v)};
    endfunction

    function automatic vdp_types_pkg::copper_word_t compressed_word(logic nl, int d, int r);
        return {copper_isa_pkg::op_write_compressed, 2'b00, nl, 5'(d), 6'(r)};
    endfunction

    function automatic vdp_types_pkg::copper_word_t write_reg_word(int mode, logic aw, int n,
                                                                   int base);
        return {copper_isa_pkg::op_write_reg, 2'(mode), aw, 5'(n), 6'(base)};
    endfunction

    function automatic vdp_types_pkg::copper_word_t jump_word(int target);
        return {copper_isa_pkg::op_jump, 3'b000, 11'(target)};
    endfunction

    // reference model: walk the program and list the writes it produces
    function automatic void build_expected(int max_writes);
        int pc;
        int size;
        int word;
        copper_isa_pkg::copper_op_t op;
        exp_addr.delete();
        exp_data.delete();
        exp_batch.delete();
        pc = 0;
        while (exp_addr.size() < max_writes) begin
            op = copper_isa_pkg::copper_op_t'(prog[pc][15:14]);
            if (op == copper_isa_pkg::op_set_target) begin
                pc++;
            end else if (op == copper_isa_pkg::op_write_compressed) begin
                exp_addr.push_back(prog[pc][5:0]);
                exp_data.push_back(prog[pc][10:6]);
                exp_batch.push_back(0);
                pc++;
            end else if (op == copper_isa_pkg::op_write_reg) begin
                case (prog[pc][13:12])
                    2'd1: size = 2;
                    2'd2: size = 4;
                    default: size = 1;
                endcase
                word = pc + 1;
                for (int b = 0; b <= prog[pc][10:6]; b++) begin
                    for (int w = 0; w < size; w++) begin
                        exp_addr.push_back((prog[pc][5:0] + w) % 64);
                        exp_data.push_back(prog[word]);
                        exp_batch.push_back(b);
                        word++;
                    end
                end
                pc = word;
            end else if (prog[pc][10:0] == pc) begin
                break;
            end else begin
                pc = prog[pc][10:0];
            end
        end
    endfunction

    task automatic check_value(string name, int expected, int actual);
        if (expected !== actual) begin
            $display("[ERROR] t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_and_start();
        @(posedge clk);
        enable <= 1'b0;
        @(posedge clk);
        got_addr.delete();
        got_data.delete();
        got_x.delete();
        got_y.delete();
        foreach (prog[i]) begin
            prog_we   <= 1'b1;
            prog_addr <= vdp_types_pkg::copper_addr_t'(i);
            prog_data <= prog[i];
            @(posedge clk);
        end
        prog_we <= 1'b0;
        enable  <= 1'b1;
    endtask

    task automatic wait_writes(int count);
        int waited;
        waited = 0;
        while (got_addr.size() < count && waited < TEST_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (got_addr.size() < count) begin
            $display("timeout: only %0d of %0d register writes arrived", got_addr.size(), count);
            errors++;
        end
    endtask

    task automatic compare_writes(int count, logic allow_more);
        for (int i = 0; i < count && i < got_addr.size(); i++) begin
            check_value($sformatf("reg_write_address[%0d]", i), exp_addr[i], got_addr[i]);
            check_value($sformatf("reg_write_data[%0d]", i), exp_data[i], got_data[i]);
        end
        if (got_addr.size() < count) begin
            $display("missing writes: %0d expected, %0d seen", count, got_addr.size());
            errors++;
        end else if (got_addr.size() > count && !allow_more) begin
            $display("extra writes: %0d expected, %0d seen", count, got_addr.size());
            errors++;
        end
    endtask

    // host read back of the last value written to each register
    task automatic check_readback(int upto);
        int last [int];
        for (int i = 0; i < upto; i++) begin
            last[exp_addr[i]] = exp_data[i];
        end
        foreach (last[a]) begin
            @(posedge clk);
            reg_read_address <= vdp_types_pkg::vdp_reg_addr_t'(a);
            @(negedge clk);
            check_value($sformatf("reg_read_data[%0d]", a), last[a], reg_read_data);
        end
    endtask

    task automatic run_and_compare();
        build_expected(256);
        load_and_start();
        wait_writes(exp_addr.size());
        repeat (8) @(posedge clk);
        compare_writes(exp_addr.size(), 1'b0);
    endtask

    task automatic finish_test(string name);
        if (errors == errors_before) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    initial begin
        int count;
        int xt;
        int yt;
        int k;
        rst_n            = 1'b0;
        enable           = 1'b0;
        prog_we          = 1'b0;
        prog_addr        = '0;
        prog_data        = '0;
        reg_read_address = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // 1: run of compressed writes
        prog.delete();
        for (int i = 0; i < 12; i++) begin
            prog.push_back(compressed_word(pick(2), pick(32), pick(64)));
        end
        prog.push_back(jump_word(prog.size()));
        run_and_compare();
        check_readback(exp_addr.size());
        finish_test("compressed writes");

        // 2: batches for modes 0..2, no auto-wait
        for (int m = 0; m < 3; m++) begin
            count = pick(4);
            prog.delete();
            prog.push_back(write_reg_word(m, 1'b0, count, pick(64)));
            repeat ((count + 1) * (1 << m)) begin
                prog.push_back(vdp_types_pkg::copper_word_t'(pick(65536)));
            end
            prog.push_back(jump_word(prog.size()));
            run_and_compare();
        end
        finish_test("batch register writes");

        // 3: write placed after a waiting target
        xt = pick(H_TOTAL - HIT_TO_WRITE);
        yt = pick(V_TOTAL);
        prog.delete();
        prog.push_back(target_word(1'b0, 1'b0, xt));
        prog.push_back(target_word(1'b1, 1'b1, yt));
        prog.push_back(compressed_word(1'b0, pick(32), pick(64)));
        prog.push_back(jump_word(3));
        run_and_compare();
        if (got_addr.size() > 0) begin
            check_value("raster_y", yt, got_y[0]);
            check_value("raster_x", xt + HIT_TO_WRITE, got_x[0]);
        end
        finish_test("raster wait");

        // 4: auto-wait batches, one line per batch
        count = 1 + pick(3);
        yt = pick(V_TOTAL - count);
        k = pick(3);
        prog.delete();
        prog.push_back(target_word(1'b0, 1'b0, 0));
        prog.push_back(target_word(1'b1, 1'b1, yt));
        prog.push_back(write_reg_word(k, 1'b1, count, pick(64)));
        repeat ((count + 1) * (1 << k)) begin
            prog.push_back(vdp_types_pkg::copper_word_t'(pick(65536)));
        end
        prog.push_back(jump_word(prog.size()));
        run_and_compare();
        for (int i = 0; i < got_y.size() && i < exp_batch.size(); i++) begin
            check_value($sformatf("raster_y[%0d]", i), yt + exp_batch[i], got_y[i]);
        end
        finish_test("auto-wait batches");

        // 5: jump over a write, then loop back to the start
        prog.delete();
        prog.push_back(compressed_word(1'b0, pick(32), pick(64)));
        prog.push_back(jump_word(3));
        prog.push_back(compressed_word(1'b0, pick(32), pick(64)));
        prog.push_back(compressed_word(1'b0, pick(32), pick(64)));
        prog.push_back(jump_word(0));
        build_expected(16);
        load_and_start();
        wait_writes(16);
        enable <= 1'b0;
        compare_writes(16, 1'b1);
        finish_test("jump");

        // 6: drop enable mid-program, then restart from address 0
        prog.delete();
        for (int i = 0; i < 8; i++) begin
            prog.push_back(compressed_word(1'b0, pick(32), pick(64)));
        end
        prog.push_back(jump_word(8));
        build_expected(64);
        k = 1 + pick(7);
        load_and_start();
        wait_writes(k);
        enable <= 1'b0;
        repeat (20) @(posedge clk);
        compare_writes(k, 1'b0);
        check_readback(k);
        got_addr.delete();
        got_data.delete();
        @(posedge clk);
        enable <= 1'b1;
        wait_writes(8);
        repeat (8) @(posedge clk);
        compare_writes(8, 1'b0);
        check_readback(8);
        finish_test("enable drop and restart");

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
src/vdp_types_pkg.sv
src/copper_isa_pkg.sv
src/raster_timer.sv
src/copper_ram.sv
src/vdp_copper.sv
src/vdp_reg_file.sv
src/vdp_copper_top.sv
verification/vdp_copper_assertions.sv
verification/vdp_copper_tb.sv
